/* include/pixel_writer_macros.svh */
`ifndef PIXEL_WRITER_MACROS_SVH
`define PIXEL_WRITER_MACROS_SVH

// RAM side of the pixel writer
`define ADDR_W 20    // word address into display RAM
`define DATA_W 16    // one RAM word holds 1 to 16 pixels

// command side
`define COLOUR_W 8   // immediate colour carried by a command
`define CMD_W 40     // op, colour, bpp, target, address

// command word field positions, top bit down
`define CMD_OP_HI 39
`define CMD_OP_LO 36
`define CMD_COLOUR_HI 35
`define CMD_COLOUR_LO 28
`define CMD_BPP_HI 27
`define CMD_BPP_LO 24
`define CMD_TARGET_HI 23
`define CMD_TARGET_LO 20
`define CMD_ADDR_HI 19   // address sits in the low bits

// collision statistics
`define COLL_W 8     // saturating counters, stop at all ones

`endif

/* logic/pixel_writer_pkg.sv */
`include "pixel_writer_macros.svh"

package pixel_writer_pkg;

    // command opcodes understood by the writer
    typedef enum logic [3:0] {
        op_nop           = 4'd0,   // popped and dropped
        op_write         = 4'd1,   // plain pixel write
        op_write_masked  = 4'd2,   // colour 0 is transparent
        op_rst_collision = 4'd10   // clear both collision counters
    } pixel_op_t;

    // pixel depth code, value is bits per pixel minus one
    typedef enum logic [3:0] {
        bpp_1  = 4'd0,
        bpp_2  = 4'd1,
        bpp_4  = 4'd3,
        bpp_8  = 4'd7,
        bpp_16 = 4'd15
    } bpp_t;

    // pixel index inside a RAM word, leftmost pixel is 0
    typedef logic [3:0] target_t;

    typedef logic [`ADDR_W-1:0] word_addr_t;   // RAM word address
    typedef logic [`DATA_W-1:0] word_t;        // RAM word
    typedef logic [`COLOUR_W-1:0] colour_t;    // immediate pixel colour

endpackage

/* logic/cmd_fifo.sv */
`timescale 1ns/1ps
`include "pixel_writer_macros.svh"

module cmd_fifo #(
    parameter int width = `CMD_W           // any payload width works
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,         // source strobe, only while not full
    input  logic             pop,          // consumer takes the head word
    input  logic [width-1:0] data_in,
    output logic             not_empty,    // head slot holds a word
    output logic             full,         // both slots hold a word
    output logic [width-1:0] data_out      // head word, shown without a read delay
);

    logic [width-1:0] slot_head;           // word at the output
    logic [width-1:0] slot_tail;           // second word, waits behind the head
    logic             head_valid;
    logic             tail_valid;
    logic             pop_ok;              // pop only counts with a head word

    assign pop_ok    = pop && head_valid;
    assign not_empty = head_valid;
    assign full      = tail_valid;
    assign data_out  = slot_head;

    // occupancy flags
    always_ff @(posedge clk) begin
        if (reset) begin
            head_valid <= 1'b0;
            tail_valid <= 1'b0;
        end else begin
            case ({push, pop_ok})
                2'b10: begin
                    if (head_valid) tail_valid <= 1'b1;   // head busy, park in the tail
                    else            head_valid <= 1'b1;   // empty, lands straight at the output
                end
                2'b01: begin
                    head_valid <= tail_valid;             // tail moves up if present
                    tail_valid <= 1'b0;
                end
                default: ;                                // idle, or push and pop balance out
            endcase
        end
    end

    // payload moves, no reset needed
    always_ff @(posedge clk) begin
        if (push && pop_ok) begin
            if (tail_valid) begin
                slot_head <= slot_tail;
                slot_tail <= data_in;
            end else begin
                slot_head <= data_in;                     // head replaced in place
            end
        end else if (push) begin
            if (head_valid) slot_tail <= data_in;
            else            slot_head <= data_in;
        end else if (pop_ok) begin
            slot_head <= slot_tail;                       // stale when tail is empty, flag says so
        end
    end

    // source must watch the full flag
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset) full |-> !push)
        else $error("cmd_fifo push while full, command lost");

endmodule

/* logic/pixel_merge.sv */
`timescale 1ns/1ps

module pixel_merge
    import pixel_writer_pkg::*;
(
    input  word_t   old_word,        // word the pixel lands in
    input  colour_t colour,
    input  bpp_t    bpp,
    input  target_t target,          // pixel index, 0 is the leftmost
    input  logic    masked,          // colour 0 means transparent
    output word_t   new_word,
    output logic    old_pixel_zero   // pixel being replaced was 0
);

    word_t      field_mask;          // low aligned mask for one pixel
    logic [3:0] shift;               // bit position of the pixel's lsb
    word_t      place_mask;          // mask moved onto the pixel
    word_t      colour_field;        // colour clipped and moved onto the pixel
    word_t      old_field;           // old pixel, low aligned
    word_t      merged;

    // mask width and shift per depth
    always_comb begin
        case (bpp)
            bpp_2: begin
                field_mask = 16'h0003;
                shift      = 4'd14 - {target[2:0], 1'b0};    // 8 pixels per word
            end
            bpp_4: begin
                field_mask = 16'h000F;
                shift      = 4'd12 - {target[1:0], 2'b00};   // 4 pixels per word
            end
            bpp_8: begin
                field_mask = 16'h00FF;
                shift      = 4'd8 - {target[0], 3'b000};     // upper byte first
            end
            bpp_16: begin
                field_mask = 16'hFFFF;
                shift      = 4'd0;                           // whole word, target ignored
            end
            default: begin
                field_mask = 16'h0001;                       // 1 bpp and the illegal codes
                shift      = 4'd15 - target;
            end
        endcase
    end

    always_comb begin
        place_mask   = field_mask << shift;
        colour_field = (word_t'(colour) & field_mask) << shift;
        merged       = (old_word & ~place_mask) | colour_field;
        old_field    = (old_word >> shift) & field_mask;
    end

    assign old_pixel_zero = (old_field == '0);
    // transparent colour leaves the word as it was
    assign new_word       = (masked && (colour == '0)) ? old_word : merged;

endmodule

/* logic/collision_counters.sv */
`timescale 1ns/1ps
`include "pixel_writer_macros.svh"

module collision_counters
    import pixel_writer_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               inc_rd,         // write landed on a nonzero pixel
    input  logic               inc_wr,         // nonzero pixel really overwritten
    input  logic               clr_rd,         // external clear strobes
    input  logic               clr_wr,
    input  logic               clear_cmd,      // reset-collision command clears both
    output logic [`COLL_W-1:0] collision_rd,
    output logic [`COLL_W-1:0] collision_wr
);

    logic rd_at_max;
    logic wr_at_max;

    assign rd_at_max = (collision_rd == '1);
    assign wr_at_max = (collision_wr == '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            collision_rd <= '0;
            collision_wr <= '0;
        end else begin
            if (clr_rd || clear_cmd) collision_rd <= '0;           // clear beats increment
            else if (inc_rd && !rd_at_max) collision_rd <= collision_rd + 1'b1;

            if (clr_wr || clear_cmd) collision_wr <= '0;
            else if (inc_wr && !wr_at_max) collision_wr <= collision_wr + 1'b1;
        end
    end

    // external clears come as single-cycle strobes
    a_clr_rd_strobe: assert property (@(posedge clk) disable iff (reset) clr_rd |=> !clr_rd)
        else $error("collision_rd_rst held longer than one cycle");

    a_clr_wr_strobe: assert property (@(posedge clk) disable iff (reset) clr_wr |=> !clr_wr)
        else $error("collision_wr_rst held longer than one cycle");

endmodule

/* logic/pixel_writer_ctrl.sv */
`timescale 1ns/1ps
`include "pixel_writer_macros.svh"

module pixel_writer_ctrl
    import pixel_writer_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,       // FIFO head holds a command
    input  logic [`CMD_W-1:0] cmd_word,
    input  logic              ram_mux_busy,    // RAM port taken, hold issue
    input  logic              rd_data_rdy_b,   // read return strobe
    input  word_t             rd_data_in,
    input  word_t             new_word,        // merged word from pixel_merge
    input  logic              old_pixel_zero,
    output logic              cmd_pop,
    output logic              rd_req_b,
    output logic              wr_ena,
    output word_addr_t        ram_addr,
    output word_t             ram_wr_data,
    output word_t             sel_word,        // word the pixel goes into
    output colour_t           sel_colour,
    output bpp_t              sel_bpp,
    output target_t           sel_target,
    output logic              sel_masked,
    output logic              inc_rd,          // old pixel was nonzero
    output logic              inc_wr,          // nonzero pixel actually overwritten
    output logic              clear_cmd        // reset-collision command popped
);

    pixel_op_t  cmd_op;
    colour_t    cmd_colour;
    bpp_t       cmd_bpp;
    target_t    cmd_target;
    word_addr_t cmd_addr;
    logic       write_cmd;                     // plain or masked write
    logic       masked_cmd;

    word_addr_t wc_addr;                       // address of the cached word
    word_t      wc_word;                       // last word written
    logic       wc_valid;
    logic       wc_hit;
    logic       rd_wait;                       // miss in flight, waiting on RAM
    logic       rd_done;                       // read data arrives this cycle
    logic       hit_write;                     // write issued straight from the cache
    logic       suppressed;                    // masked write with colour 0

    colour_t    lat_colour;                    // fields of the command that missed
    bpp_t       lat_bpp;
    target_t    lat_target;
    logic       lat_masked;

    // field breakout of the FIFO head
    assign cmd_op     = pixel_op_t'(cmd_word[`CMD_OP_HI:`CMD_OP_LO]);
    assign cmd_colour = cmd_word[`CMD_COLOUR_HI:`CMD_COLOUR_LO];
    assign cmd_bpp    = bpp_t'(cmd_word[`CMD_BPP_HI:`CMD_BPP_LO]);   // illegal codes fall to 1 bpp
    assign cmd_target = cmd_word[`CMD_TARGET_HI:`CMD_TARGET_LO];
    assign cmd_addr   = cmd_word[`CMD_ADDR_HI:0];

    assign write_cmd  = (cmd_op == op_write) || (cmd_op == op_write_masked);
    assign masked_cmd = (cmd_op == op_write_masked);
    assign wc_hit     = wc_valid && (cmd_addr == wc_addr);

    // a miss cannot read while the port still shows the latched write address
    assign cmd_pop   = cmd_valid && !rd_wait && !ram_mux_busy && !(wr_ena && !wc_hit);
    assign rd_req_b  = cmd_pop && write_cmd && !wc_hit;
    assign hit_write = cmd_pop && write_cmd && wc_hit;
    assign clear_cmd = cmd_pop && (cmd_op == op_rst_collision);
    assign rd_done   = rd_wait && rd_data_rdy_b;
    assign ram_addr  = wr_ena ? wc_addr : cmd_addr;

    // merge geometry, latched fields with RAM data while a read is open
    assign sel_word   = rd_wait ? rd_data_in : wc_word;
    assign sel_colour = rd_wait ? lat_colour : cmd_colour;
    assign sel_bpp    = rd_wait ? lat_bpp    : cmd_bpp;
    assign sel_target = rd_wait ? lat_target : cmd_target;
    assign sel_masked = rd_wait ? lat_masked : masked_cmd;
    assign suppressed = sel_masked && (sel_colour == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ena   <= 1'b0;
            wc_valid <= 1'b0;
            rd_wait  <= 1'b0;
            inc_rd   <= 1'b0;
            inc_wr   <= 1'b0;
        end else begin
            wr_ena <= rd_done || hit_write;                  // one cycle write strobe
            inc_rd <= (rd_done || hit_write) && !old_pixel_zero;
            inc_wr <= (rd_done || hit_write) && !old_pixel_zero && !suppressed;
            if (rd_done) begin
                rd_wait  <= 1'b0;
                wc_valid <= 1'b1;                            // cache now holds the fresh word
            end else if (rd_req_b) begin
                rd_wait  <= 1'b1;                            // stall issue until data is back
                wc_valid <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (rd_done || hit_write) begin
            ram_wr_data <= new_word;
            wc_word     <= new_word;                         // next hit merges into this
        end
        if (rd_req_b) begin
            wc_addr    <= cmd_addr;
            lat_colour <= cmd_colour;
            lat_bpp    <= cmd_bpp;
            lat_target <= cmd_target;
            lat_masked <= masked_cmd;
        end
    end

    // RAM only answers a read that is open
    a_rdy_needs_read: assert property (@(posedge clk) disable iff (reset)
        rd_data_rdy_b |-> rd_wait)
        else $error("read data strobe with no read request open");

endmodule

/* logic/geo_pixel_writer.sv */
`timescale 1ns/1ps
`include "pixel_writer_macros.svh"

module geo_pixel_writer
    import pixel_writer_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_rdy,            // command strobe from the drawing engine
    input  logic [`CMD_W-1:0]  cmd_in,
    input  word_t              rd_data_in,
    input  logic               rd_data_rdy_b,      // read data valid strobe
    input  logic               ram_mux_busy,
    input  logic               collision_rd_rst,
    input  logic               collision_wr_rst,
    output logic               draw_busy,          // command buffer full
    output logic               rd_req_b,
    output logic               wr_ena,
    output word_addr_t         ram_addr,
    output word_t              ram_wr_data,
    output logic [`COLL_W-1:0] collision_rd,
    output logic [`COLL_W-1:0] collision_wr
);

    logic              cmd_valid;
    logic              cmd_pop;
    logic [`CMD_W-1:0] cmd_word;
    word_t             sel_word;
    colour_t           sel_colour;
    bpp_t              sel_bpp;
    target_t           sel_target;
    logic              sel_masked;
    word_t             new_word;
    logic              old_pixel_zero;
    logic              inc_rd;
    logic              inc_wr;
    logic              clear_cmd;

    cmd_fifo #(
        .width(`CMD_W)
    ) u_cmd_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (cmd_rdy),
        .pop       (cmd_pop),
        .data_in   (cmd_in),
        .not_empty (cmd_valid),
        .full      (draw_busy),                    // source holds off while high
        .data_out  (cmd_word)
    );

    pixel_writer_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_word       (cmd_word),
        .ram_mux_busy   (ram_mux_busy),
        .rd_data_rdy_b  (rd_data_rdy_b),
        .rd_data_in     (rd_data_in),
        .new_word       (new_word),
        .old_pixel_zero (old_pixel_zero),
        .cmd_pop        (cmd_pop),
        .rd_req_b       (rd_req_b),
        .wr_ena         (wr_ena),
        .ram_addr       (ram_addr),
        .ram_wr_data    (ram_wr_data),
        .sel_word       (sel_word),
        .sel_colour     (sel_colour),
        .sel_bpp        (sel_bpp),
        .sel_target     (sel_target),
        .sel_masked     (sel_masked),
        .inc_rd         (inc_rd),
        .inc_wr         (inc_wr),
        .clear_cmd      (clear_cmd)
    );

    pixel_merge u_merge (
        .old_word       (sel_word),
        .colour         (sel_colour),
        .bpp            (sel_bpp),
        .target         (sel_target),
        .masked         (sel_masked),
        .new_word       (new_word),
        .old_pixel_zero (old_pixel_zero)
    );

    collision_counters u_counters (
        .clk          (clk),
        .reset        (reset),
        .inc_rd       (inc_rd),
        .inc_wr       (inc_wr),
        .clr_rd       (collision_rd_rst),
        .clr_wr       (collision_wr_rst),
        .clear_cmd    (clear_cmd),
        .collision_rd (collision_rd),
        .collision_wr (collision_wr)
    );

endmodule

/* test/ram_model.sv */
`timescale 1ns/1ps

module ram_model
    import pixel_writer_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rd_req_b,        // read request strobe from the DUT
    input  logic       wr_ena,
    input  word_addr_t ram_addr,
    input  word_t      ram_wr_data,
    output word_t      rd_data_in,
    output logic       rd_data_rdy_b,   // one cycle answer strobe
    output logic       ram_mux_busy     // port taken by another master
);

    word_t      mem [0:63];             // preloaded by the testbench
    logic [5:0] req_addr;               // word asked for by the open read
    int         req_wait = 0;           // cycles left until the answer, 0 when idle

    initial begin
        rd_data_in    = '0;
        rd_data_rdy_b = 1'b0;
        ram_mux_busy  = 1'b0;
    end

    // writes land and requests are taken on the rising edge
    always @(posedge clk) begin
        if (reset) begin
            req_wait <= 0;
        end else begin
            if (wr_ena) mem[ram_addr[5:0]] <= ram_wr_data;
            if (rd_req_b) begin
                req_addr <= ram_addr[5:0];
                req_wait <= 1 + ($urandom % 4);   // answer after 1 to 4 cycles
            end else if (req_wait != 0) begin
                req_wait <= req_wait - 1;
            end
        end
    end

    // outputs change on the falling edge like every other DUT input
    always @(negedge clk) begin
        rd_data_rdy_b = (req_wait == 1);
        if (req_wait == 1) rd_data_in = mem[req_addr];
        ram_mux_busy  = !reset && ($urandom % 4 == 0);   // about one cycle in four
    end

endmodule

/* test/tb_geo_pixel_writer.sv */
`timescale 1ns/1ps
`include "pixel_writer_macros.svh"

module tb_geo_pixel_writer
    import pixel_writer_pkg::*;
();

    localparam int n_plain     = 120;
    localparam int n_masked    = 60;
    localparam int n_fill      = 8;     // words primed before the saturation run
    localparam int n_sat       = 270;   // more than 255 hits on nonzero pixels
    localparam int n_recount   = 20;
    localparam int n_mixed     = 100;
    // at most 8 cycles per command, plus room for resets and drains
    localparam int cycle_limit =
        (n_plain + n_masked + n_fill + n_sat + n_recount + n_mixed + 2) * 8 + 400;

    logic               clk;
    logic               reset;
    logic               cmd_rdy;
    logic [`CMD_W-1:0]  cmd_in;
    word_t              rd_data_in;
    logic               rd_data_rdy_b;
    logic               ram_mux_busy;
    logic               collision_rd_rst;
    logic               collision_wr_rst;
    logic               draw_busy;
    logic               rd_req_b;
    logic               wr_ena;
    word_addr_t         ram_addr;
    word_t              ram_wr_data;
    logic [`COLL_W-1:0] collision_rd;
    logic [`COLL_W-1:0] collision_wr;

    word_t             model_mem [0:63];   // RAM image as the commands should leave it
    logic [7:0]        coll_rd = '0;       // model counters
    logic [7:0]        coll_wr = '0;
    logic [`CMD_W-1:0] cmd_q [$];          // commands waiting for the source
    logic [51:0]       exp_q [$];          // {addr, data, coll_rd, coll_wr} per write
    logic [51:0]       seen;
    logic [5:0]        last_addr = '0;
    logic              burst = 1'b0;       // send on every free cycle
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                base_errors;
    int                base_checks;
    int                full_cycles = 0;
    int                cycles = 0;

    geo_pixel_writer uut (.*);

    ram_model u_ram (
        .clk           (clk),
        .reset         (reset),
        .rd_req_b      (rd_req_b),
        .wr_ena        (wr_ena),
        .ram_addr      (ram_addr),
        .ram_wr_data   (ram_wr_data),
        .rd_data_in    (rd_data_in),
        .rd_data_rdy_b (rd_data_rdy_b),
        .ram_mux_busy  (ram_mux_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [3:0] pick_bpp();
        case ($urandom % 5)
            0: return bpp_1;
            1: return bpp_2;
            2: return bpp_4;
            3: return bpp_8;
            default: return bpp_16;
        endcase
    endfunction

    // pixel rule: field of bits at 16 - bits * (slot + 1), slot = target mod pixels per word
    task automatic model_write(input logic [5:0] addr, input logic [7:0] colour,
                               input logic [3:0] bpp, input logic [3:0] target,
                               input logic masked);
        int    bits;
        int    shift;
        word_t field_mask;
        word_t old;
        word_t upd;
        logic  old_nonzero;
        logic  skip;
        bits        = bpp + 1;
        shift       = 16 - bits * ((target % (16 / bits)) + 1);
        field_mask  = 16'((32'd1 << bits) - 1);
        old         = model_mem[addr];
        old_nonzero = ((old >> shift) & field_mask) != 0;
        skip        = masked && (colour == 8'h00);          // transparent pixel
        upd         = (old & ~(field_mask << shift)) | ((16'(colour) & field_mask) << shift);
        if (skip) upd = old;
        exp_q.push_back({20'(addr), upd, coll_rd, coll_wr});    // counters before this write
        model_mem[addr] = upd;
        if (old_nonzero && coll_rd != 8'hFF) coll_rd++;
        if (old_nonzero && !skip && coll_wr != 8'hFF) coll_wr++;
    endtask

    task automatic queue_cmd(input logic [3:0] op, input logic [7:0] colour,
                             input logic [3:0] bpp, input logic [3:0] target,
                             input logic [5:0] addr);
        cmd_q.push_back({op, colour, bpp, target, 14'd0, addr});
        if (op == op_write || op == op_write_masked) begin
            model_write(addr, colour, bpp, target, op == op_write_masked);
        end else if (op == op_rst_collision) begin
            coll_rd = '0;
            coll_wr = '0;
        end
    endtask

    task automatic random_write(input logic masked, input int span);
        logic [5:0] addr;
        logic [7:0] colour;
        addr   = ($urandom % 4 == 0) ? last_addr : 6'($urandom % span);   // repeats give hits
        colour = 8'($urandom);
        if (masked && $urandom % 2 == 0) colour = 8'h00;
        last_addr = addr;
        queue_cmd(masked ? op_write_masked : op_write, colour, pick_bpp(), 4'($urandom), addr);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (cmd_q.size() != 0 || cmd_rdy || uut.cmd_valid || exp_q.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);   // counters move one cycle after the last write
    endtask

    task automatic compare_ram();
        for (int i = 0; i < 64; i++)
            check_value($sformatf("ram word %0d", i), u_ram.mem[i], model_mem[i]);
        check_value("collision_rd", collision_rd, coll_rd);
        check_value("collision_wr", collision_wr, coll_wr);
    endtask

    task automatic start_test();
        base_errors = errors;
        base_checks = checks;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-34s checks %0d, errors %0d", name, checks - base_checks,
                 errors - base_errors);
    endtask

    // command source, holds back while the buffer is full
    initial begin
        cmd_rdy = 1'b0;
        cmd_in  = '0;
        forever begin
            @(negedge clk);
            if (!reset && cmd_q.size() > 0 && !draw_busy && (burst || $urandom % 2 == 0)) begin
                cmd_rdy = 1'b1;
                cmd_in  = cmd_q.pop_front();
            end else begin
                cmd_rdy = 1'b0;
            end
        end
    end

    // every write strobe is checked against the next expected write in command order
    always @(negedge clk) begin
        if (!reset) begin
            if (draw_busy) full_cycles++;
            if (wr_ena) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("write strobe at %0t with no write command outstanding", $time);
                end else begin
                    seen = exp_q.pop_front();
                    check_value("write address", ram_addr, seen[51:32]);
                    check_value("write data", ram_wr_data, seen[31:16]);
                    check_value("collision_rd at write", collision_rd, seen[15:8]);
                    check_value("collision_wr at write", collision_wr, seen[7:0]);
                end
            end
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped applying commands", cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        word_t w;
        int    base_full;
        int    r;
        void'($urandom(13));
        reset            = 1'b1;
        collision_rd_rst = 1'b0;
        collision_wr_rst = 1'b0;
        for (int i = 0; i < 64; i++) begin
            w               = 16'($urandom);
            u_ram.mem[i]    = w;
            model_mem[i]    = w;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test();
        check_value("wr_ena after reset", wr_ena, 0);
        check_value("rd_req_b after reset", rd_req_b, 0);
        check_value("draw_busy after reset", draw_busy, 0);
        check_value("collision_rd after reset", collision_rd, 0);
        check_value("collision_wr after reset", collision_wr, 0);
        end_test("reset values");

        start_test();
        repeat (n_plain) random_write(1'b0, 64);
        wait_idle();
        compare_ram();
        end_test("plain writes, all depths");

        start_test();
        repeat (n_masked) random_write(1'b1, 64);
        wait_idle();
        compare_ram();
        end_test("masked writes");

        start_test();
        queue_cmd(op_rst_collision, 8'h00, bpp_1, 4'd0, 6'd0);
        for (int i = 0; i < n_fill; i++)
            queue_cmd(op_write, 8'($urandom % 255 + 1), bpp_16, 4'd0, 6'(i));
        repeat (n_sat)                                          // nonzero onto nonzero words
            queue_cmd(($urandom % 2) ? op_write : op_write_masked, 8'($urandom % 255 + 1),
                      bpp_16, 4'($urandom), 6'($urandom % n_fill));
        wait_idle();
        compare_ram();
        check_value("collision_rd saturated", collision_rd, 8'hFF);
        check_value("collision_wr saturated", collision_wr, 8'hFF);
        end_test("collision counter saturation");

        start_test();
        collision_rd_rst = 1'b1;
        @(negedge clk);
        collision_rd_rst = 1'b0;
        coll_rd = '0;
        check_value("collision_rd after clear strobe", collision_rd, 0);
        check_value("collision_wr kept", collision_wr, 8'hFF);
        collision_wr_rst = 1'b1;
        @(negedge clk);
        collision_wr_rst = 1'b0;
        coll_wr = '0;
        check_value("collision_wr after clear strobe", collision_wr, 0);
        repeat (n_recount)
            queue_cmd(op_write, 8'($urandom % 255 + 1), bpp_16, 4'd0, 6'($urandom % n_fill));
        wait_idle();
        compare_ram();
        queue_cmd(op_rst_collision, 8'h00, bpp_1, 4'd0, 6'd0);
        wait_idle();
        compare_ram();
        end_test("counter clears");

        start_test();
        base_full = full_cycles;
        burst     = 1'b1;
        repeat (n_mixed) begin
            r = $urandom % 16;
            if (r < 8) random_write(1'b0, 16);
            else if (r < 12) random_write(1'b1, 16);
            else if (r < 14) queue_cmd(op_nop, 8'($urandom), pick_bpp(), 4'($urandom), 6'(r));
            else queue_cmd(op_rst_collision, 8'h00, bpp_1, 4'd0, 6'd0);
        end
        wait_idle();
        burst = 1'b0;
        compare_ram();
        if (full_cycles == base_full) begin
            errors++;
            $display("the command buffer never filled during the back-pressure run");
        end
        end_test("mixed commands under back-pressure");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
logic/pixel_writer_pkg.sv
logic/cmd_fifo.sv
logic/pixel_merge.sv
logic/collision_counters.sv
logic/pixel_writer_ctrl.sv
logic/geo_pixel_writer.sv
test/ram_model.sv
test/tb_geo_pixel_writer.sv

/* Bender.yml */
package:
  name: geo_pixel_writer

sources:
  - include_dirs:
      - include
    files:
      - logic/pixel_writer_pkg.sv
      - logic/cmd_fifo.sv
      - logic/pixel_merge.sv
      - logic/collision_counters.sv
      - logic/pixel_writer_ctrl.sv
      - logic/geo_pixel_writer.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ram_model.sv
      - test/tb_geo_pixel_writer.sv
